/* hdl/lc3b_isa_pkg.sv */
package lc3b_isa_pkg;

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;

// condition codes in n, z, p order
typedef logic [2:0] lc3b_nzp;

typedef enum logic [3:0]
{
	op_br   = 4'b0000,
	op_add  = 4'b0001,
	op_ldb  = 4'b0010,
	op_stb  = 4'b0011,
	op_jsr  = 4'b0100,
	op_and  = 4'b0101,
	op_ldr  = 4'b0110,
	op_str  = 4'b0111,
	op_rti  = 4'b1000,
	op_not  = 4'b1001,
	op_jmp  = 4'b1100,
	op_shf  = 4'b1101,
	op_lea  = 4'b1110,
	op_trap = 4'b1111
} lc3b_opcode;

// the same 16 bits read as an operate format or as a branch format
typedef union packed
{
	struct packed
	{
		lc3b_opcode opcode;
		lc3b_reg dr;
		lc3b_reg sr1;
		logic imm;
		logic [1:0] spare;
		lc3b_reg sr2;
	} regs;
	struct packed
	{
		lc3b_opcode opcode;
		lc3b_nzp nzp;
		logic [8:0] offset9;
	} br;
} lc3b_instr;

endpackage : lc3b_isa_pkg

/* hdl/lc3b_ctrl_pkg.sv */
package lc3b_ctrl_pkg;

typedef logic [2:0] lc3b_aluop;

localparam lc3b_aluop alu_add  = 3'd0;
localparam lc3b_aluop alu_and  = 3'd1;
localparam lc3b_aluop alu_not  = 3'd2;
localparam lc3b_aluop alu_pass = 3'd3;
localparam lc3b_aluop alu_sll  = 3'd4;
localparam lc3b_aluop alu_srl  = 3'd5;
localparam lc3b_aluop alu_sra  = 3'd6;

typedef enum logic [1:0]
{
	pc_none   = 2'b00,
	pc_branch = 2'b01,
	pc_jump   = 2'b10,
	pc_sub    = 2'b11
} lc3b_pc_ctrl;

typedef struct packed
{
	lc3b_isa_pkg::lc3b_opcode opcode;
	lc3b_aluop aluop;
	logic sr1_needed;
	logic sr2_needed;
	logic cc_needed;
	logic ld_reg;
	logic ld_cc;
	logic regfilemux_sel;
	logic destmux_sel;
	logic mem_read;
	logic mem_write;
	logic mem_byte;
	lc3b_pc_ctrl pc_ctrl;
} lc3b_control_word;

// JSR and TRAP save the return address here
localparam lc3b_isa_pkg::lc3b_reg link_reg = 3'd7;

localparam lc3b_control_word nop_cw = '0;

endpackage : lc3b_ctrl_pkg

/* hdl/hazard_if.sv */
interface hazard_if;

	lc3b_isa_pkg::lc3b_reg ex_drid;
	lc3b_isa_pkg::lc3b_reg mem_drid;
	lc3b_isa_pkg::lc3b_reg wb_drid;

	logic ex_ld_reg;
	logic mem_ld_reg;
	logic wb_ld_reg;

	logic ex_ld_cc;
	logic mem_ld_cc;
	logic wb_ld_cc;

	modport stages (output ex_drid, mem_drid, wb_drid, ex_ld_reg, mem_ld_reg, wb_ld_reg,
		ex_ld_cc, mem_ld_cc, wb_ld_cc);

	modport check (input ex_drid, mem_drid, wb_drid, ex_ld_reg, mem_ld_reg, wb_ld_reg,
		ex_ld_cc, mem_ld_cc, wb_ld_cc);

endinterface : hazard_if

/* hdl/control_rom.sv */
module control_rom
(
	input lc3b_isa_pkg::lc3b_instr instr,
	output lc3b_ctrl_pkg::lc3b_control_word ctrl
);

lc3b_isa_pkg::lc3b_opcode op;

assign op = instr.br.opcode;

always_comb
begin
	ctrl = lc3b_ctrl_pkg::nop_cw;
	ctrl.opcode = op;
	case (op)
		lc3b_isa_pkg::op_add,
		lc3b_isa_pkg::op_and:
		begin
			ctrl.aluop = (op == lc3b_isa_pkg::op_add) ? lc3b_ctrl_pkg::alu_add
				: lc3b_ctrl_pkg::alu_and;
			ctrl.sr1_needed = 1'b1;
			// immediate form has no second source register
			ctrl.sr2_needed = ~instr.regs.imm;
			ctrl.ld_reg = 1'b1;
			ctrl.ld_cc = 1'b1;
		end
		lc3b_isa_pkg::op_not:
		begin
			ctrl.aluop = lc3b_ctrl_pkg::alu_not;
			ctrl.sr1_needed = 1'b1;
			ctrl.ld_reg = 1'b1;
			ctrl.ld_cc = 1'b1;
		end
		lc3b_isa_pkg::op_shf:
		begin
			// bit 4 picks right shifts, bit 5 makes a right shift arithmetic
			if (!instr.regs.spare[1])
				ctrl.aluop = lc3b_ctrl_pkg::alu_sll;
			else if (instr.regs.imm)
				ctrl.aluop = lc3b_ctrl_pkg::alu_sra;
			else
				ctrl.aluop = lc3b_ctrl_pkg::alu_srl;
			ctrl.sr1_needed = 1'b1;
			ctrl.ld_reg = 1'b1;
			ctrl.ld_cc = 1'b1;
		end
		lc3b_isa_pkg::op_ldb,
		lc3b_isa_pkg::op_ldr:
		begin
			ctrl.aluop = lc3b_ctrl_pkg::alu_add;
			ctrl.sr1_needed = 1'b1;
			ctrl.ld_reg = 1'b1;
			ctrl.ld_cc = 1'b1;
			ctrl.mem_read = 1'b1;
			ctrl.mem_byte = (op == lc3b_isa_pkg::op_ldb);
		end
		lc3b_isa_pkg::op_stb,
		lc3b_isa_pkg::op_str:
		begin
			ctrl.aluop = lc3b_ctrl_pkg::alu_add;
			ctrl.sr1_needed = 1'b1;
			ctrl.sr2_needed = 1'b1;
			ctrl.regfilemux_sel = 1'b1;
			ctrl.mem_write = 1'b1;
			ctrl.mem_byte = (op == lc3b_isa_pkg::op_stb);
		end
		lc3b_isa_pkg::op_lea:
		begin
			ctrl.aluop = lc3b_ctrl_pkg::alu_pass;
			ctrl.ld_reg = 1'b1;
			ctrl.ld_cc = 1'b1;
		end
		lc3b_isa_pkg::op_br:
		begin
			ctrl.cc_needed = 1'b1;
			ctrl.pc_ctrl = lc3b_ctrl_pkg::pc_branch;
		end
		lc3b_isa_pkg::op_jmp,
		lc3b_isa_pkg::op_rti:
		begin
			ctrl.sr1_needed = 1'b1;
			ctrl.pc_ctrl = lc3b_ctrl_pkg::pc_jump;
		end
		lc3b_isa_pkg::op_jsr:
		begin
			// bit 11 set is the PC-relative form, clear is JSRR through a base register
			ctrl.sr1_needed = ~instr.regs.dr[2];
			ctrl.destmux_sel = 1'b1;
			ctrl.pc_ctrl = lc3b_ctrl_pkg::pc_sub;
		end
		lc3b_isa_pkg::op_trap:
		begin
			ctrl.destmux_sel = 1'b1;
			ctrl.mem_read = 1'b1;
			ctrl.pc_ctrl = lc3b_ctrl_pkg::pc_sub;
		end
		default:
			ctrl = lc3b_ctrl_pkg::nop_cw;
	endcase
end

endmodule : control_rom

/* hdl/reg_state.sv */
module reg_state
(
	input logic clk,
	input logic reset,
	input logic wb_ld_reg,
	input logic wb_ld_cc,
	input lc3b_isa_pkg::lc3b_reg dest_reg,
	input lc3b_isa_pkg::lc3b_reg src_a,
	input lc3b_isa_pkg::lc3b_reg src_b,
	input lc3b_isa_pkg::lc3b_word reg_data,
	input lc3b_isa_pkg::lc3b_nzp cc_data,
	output lc3b_isa_pkg::lc3b_word reg_a,
	output lc3b_isa_pkg::lc3b_word reg_b,
	output lc3b_isa_pkg::lc3b_nzp cc
);

lc3b_isa_pkg::lc3b_word regs [8];

always_ff @(posedge clk)
begin
	if (wb_ld_reg)
		regs[dest_reg] <= reg_data;
end

always_ff @(posedge clk)
begin
	if (reset)
		cc <= '0;
	else if (wb_ld_cc)
		cc <= cc_data;
end

// reads do not bypass a write in the same cycle
assign reg_a = regs[src_a];
assign reg_b = regs[src_b];

endmodule : reg_state

/* hdl/hazard_unit.sv */
module hazard_unit
(
	hazard_if.check hz,
	input logic valid_in,
	input logic execute_br_stall,
	input logic mem_stall,
	input logic mem_br_stall,
	input lc3b_isa_pkg::lc3b_reg sr1_idx,
	input lc3b_isa_pkg::lc3b_reg sr2_idx,
	input lc3b_ctrl_pkg::lc3b_control_word cw,
	output logic dep_stall,
	output logic decode_br_stall,
	output logic valid_out,
	output logic load_ex
);

logic sr1_hit;
logic sr2_hit;
logic cc_busy;
logic dep_any;

// a source is busy while any later stage still has to write it
assign sr1_hit = (hz.ex_ld_reg && hz.ex_drid == sr1_idx)
	|| (hz.mem_ld_reg && hz.mem_drid == sr1_idx)
	|| (hz.wb_ld_reg && hz.wb_drid == sr1_idx);

assign sr2_hit = (hz.ex_ld_reg && hz.ex_drid == sr2_idx)
	|| (hz.mem_ld_reg && hz.mem_drid == sr2_idx)
	|| (hz.wb_ld_reg && hz.wb_drid == sr2_idx);

assign cc_busy = hz.ex_ld_cc || hz.mem_ld_cc || hz.wb_ld_cc;

assign dep_any = (cw.sr1_needed && sr1_hit)
	|| (cw.sr2_needed && sr2_hit)
	|| (cw.cc_needed && cc_busy);

assign dep_stall = valid_in && dep_any;

assign decode_br_stall = valid_in && (cw.pc_ctrl != lc3b_ctrl_pkg::pc_none);

// the instruction goes on as a bubble when it waits or a branch is resolving
assign valid_out = valid_in && !dep_stall && !execute_br_stall && !mem_br_stall;

assign load_ex = ~mem_stall;

endmodule : hazard_unit

/* hdl/id_ex_reg.sv */
module id_ex_reg
(
	input logic clk,
	input logic reset,
	input logic load,
	input logic valid_in,
	input lc3b_isa_pkg::lc3b_word npc_in,
	input lc3b_isa_pkg::lc3b_word ir_in,
	input lc3b_isa_pkg::lc3b_word sr1_in,
	input lc3b_isa_pkg::lc3b_word sr2_in,
	input lc3b_ctrl_pkg::lc3b_control_word cw_in,
	input lc3b_isa_pkg::lc3b_nzp cc_in,
	input lc3b_isa_pkg::lc3b_reg dr_in,
	output lc3b_isa_pkg::lc3b_word npc,
	output lc3b_isa_pkg::lc3b_word ir,
	output lc3b_isa_pkg::lc3b_word sr1,
	output lc3b_isa_pkg::lc3b_word sr2,
	output lc3b_ctrl_pkg::lc3b_control_word cw,
	output lc3b_isa_pkg::lc3b_nzp cc_out,
	output lc3b_isa_pkg::lc3b_reg dr,
	output logic valid
);

always_ff @(posedge clk)
begin
	if (reset)
	begin
		npc <= '0;
		ir <= '0;
		sr1 <= '0;
		sr2 <= '0;
		cw <= lc3b_ctrl_pkg::nop_cw;
		cc_out <= '0;
		dr <= '0;
		valid <= 1'b0;
	end
	else if (load)
	begin
		npc <= npc_in;
		ir <= ir_in;
		sr1 <= sr1_in;
		sr2 <= sr2_in;
		cw <= cw_in;
		cc_out <= cc_in;
		dr <= dr_in;
		valid <= valid_in;
	end
end

endmodule : id_ex_reg

/* hdl/decode_stage.sv */
module decode_stage
(
	input logic clk,
	input logic reset,
	input lc3b_isa_pkg::lc3b_word npc_in,
	input lc3b_isa_pkg::lc3b_word ir_in,
	input lc3b_isa_pkg::lc3b_word reg_data,
	input lc3b_isa_pkg::lc3b_nzp cc_data,
	input lc3b_isa_pkg::lc3b_reg dest_reg,
	input lc3b_isa_pkg::lc3b_reg ex_drid,
	input lc3b_isa_pkg::lc3b_reg mem_drid,
	input lc3b_isa_pkg::lc3b_reg wb_drid,
	input logic ex_ld_reg,
	input logic mem_ld_reg,
	input logic wb_ld_reg,
	input logic ex_ld_cc,
	input logic mem_ld_cc,
	input logic wb_ld_cc,
	input logic valid_in,
	input logic execute_br_stall,
	input logic mem_stall,
	input logic mem_br_stall,
	output lc3b_isa_pkg::lc3b_word npc,
	output lc3b_ctrl_pkg::lc3b_control_word cw,
	output lc3b_isa_pkg::lc3b_word ir,
	output lc3b_isa_pkg::lc3b_word sr1,
	output lc3b_isa_pkg::lc3b_word sr2,
	output lc3b_isa_pkg::lc3b_nzp cc_out,
	output lc3b_isa_pkg::lc3b_reg dr,
	output logic valid,
	output logic dep_stall,
	output logic decode_br_stall
);

lc3b_isa_pkg::lc3b_instr instr;
lc3b_ctrl_pkg::lc3b_control_word cw_dec;
lc3b_isa_pkg::lc3b_reg sr1_idx;
lc3b_isa_pkg::lc3b_reg sr2_idx;
lc3b_isa_pkg::lc3b_reg dr_sel;
lc3b_isa_pkg::lc3b_word reg_a;
lc3b_isa_pkg::lc3b_word reg_b;
lc3b_isa_pkg::lc3b_nzp cc_cur;
logic valid_dec;
logic load_ex;

hazard_if hz ();

assign hz.ex_drid = ex_drid;
assign hz.mem_drid = mem_drid;
assign hz.wb_drid = wb_drid;
assign hz.ex_ld_reg = ex_ld_reg;
assign hz.mem_ld_reg = mem_ld_reg;
assign hz.wb_ld_reg = wb_ld_reg;
assign hz.ex_ld_cc = ex_ld_cc;
assign hz.mem_ld_cc = mem_ld_cc;
assign hz.wb_ld_cc = wb_ld_cc;

assign instr = ir_in;

// stores read the data register from the dr field
assign sr1_idx = instr.regs.sr1;
assign sr2_idx = cw_dec.regfilemux_sel ? instr.regs.dr : instr.regs.sr2;
assign dr_sel = cw_dec.destmux_sel ? lc3b_ctrl_pkg::link_reg : instr.regs.dr;

control_rom control_store (.instr, .ctrl(cw_dec));

reg_state state
(
	.clk, .reset, .wb_ld_reg, .wb_ld_cc, .dest_reg,
	.src_a(sr1_idx), .src_b(sr2_idx), .reg_data, .cc_data,
	.reg_a, .reg_b, .cc(cc_cur)
);

hazard_unit hazards
(
	.hz, .valid_in, .execute_br_stall, .mem_stall, .mem_br_stall,
	.sr1_idx, .sr2_idx, .cw(cw_dec),
	.dep_stall, .decode_br_stall, .valid_out(valid_dec), .load_ex
);

id_ex_reg id_ex
(
	.clk, .reset, .load(load_ex), .valid_in(valid_dec),
	.npc_in, .ir_in, .sr1_in(reg_a), .sr2_in(reg_b), .cw_in(cw_dec),
	.cc_in(cc_cur), .dr_in(dr_sel),
	.npc, .ir, .sr1, .sr2, .cw, .cc_out, .dr, .valid
);

endmodule : decode_stage

/* tb/decode_stage_assertions.sv */
module decode_stage_assertions
(
	input logic clk,
	input logic reset,
	input logic mem_stall,
	input logic load_ex,
	input logic dep_stall,
	input logic decode_br_stall,
	input logic valid_in,
	input logic valid,
	input lc3b_isa_pkg::lc3b_word ir_in,
	input lc3b_isa_pkg::lc3b_word npc,
	input lc3b_isa_pkg::lc3b_word ir,
	input lc3b_isa_pkg::lc3b_word sr1,
	input lc3b_isa_pkg::lc3b_word sr2,
	input lc3b_ctrl_pkg::lc3b_control_word cw,
	input lc3b_isa_pkg::lc3b_nzp cc_out,
	input lc3b_isa_pkg::lc3b_reg dr
);

timeunit 1ns;
timeprecision 1ps;

// a waiting instruction must enter execute as a bubble
assert property (@(posedge clk) disable iff (reset) (dep_stall && load_ex) |=> !valid)
else
	$error("valid rose after a dependency stall");

assert property (@(posedge clk) disable iff (reset)
	mem_stall |=> $stable({npc, ir, sr1, sr2, cw, cc_out, dr, valid}))
else
	$error("ID/EX register changed under mem_stall");

// a branch stall comes only from a valid control-flow opcode in the instruction word
assert property (@(posedge clk) decode_br_stall == (valid_in && ir_in[15:12] inside
	{lc3b_isa_pkg::op_br, lc3b_isa_pkg::op_jmp, lc3b_isa_pkg::op_rti,
	lc3b_isa_pkg::op_jsr, lc3b_isa_pkg::op_trap}))
else
	$error("decode_br_stall disagrees with valid_in and the opcode");

endmodule : decode_stage_assertions

bind decode_stage decode_stage_assertions checks_i
(
	.clk, .reset, .mem_stall, .load_ex, .dep_stall, .decode_br_stall, .valid_in, .valid,
	.ir_in, .npc, .ir, .sr1, .sr2, .cw, .cc_out, .dr
);

/* tb/decode_stage_tb.sv */
module decode_stage_tb;

timeunit 1ns;
timeprecision 1ps;

localparam int ctrl_len = 160;
localparam int dep_len = 200;
localparam int cc_len = 120;
localparam int br_len = 150;
localparam int bp_len = 200;
// reset and register setup take 18 cycles, and each of the six tests ends with one flush cycle
localparam int total_cycles = 18 + ctrl_len + dep_len + cc_len + br_len + bp_len + 6;

logic clk;
logic reset;
lc3b_isa_pkg::lc3b_word npc_in;
lc3b_isa_pkg::lc3b_word ir_in;
lc3b_isa_pkg::lc3b_word reg_data;
lc3b_isa_pkg::lc3b_nzp cc_data;
lc3b_isa_pkg::lc3b_reg dest_reg;
lc3b_isa_pkg::lc3b_reg ex_drid;
lc3b_isa_pkg::lc3b_reg mem_drid;
lc3b_isa_pkg::lc3b_reg wb_drid;
logic ex_ld_reg;
logic mem_ld_reg;
logic wb_ld_reg;
logic ex_ld_cc;
logic mem_ld_cc;
logic wb_ld_cc;
logic valid_in;
logic execute_br_stall;
logic mem_stall;
logic mem_br_stall;
lc3b_isa_pkg::lc3b_word npc;
lc3b_ctrl_pkg::lc3b_control_word cw;
lc3b_isa_pkg::lc3b_word ir;
lc3b_isa_pkg::lc3b_word sr1;
lc3b_isa_pkg::lc3b_word sr2;
lc3b_isa_pkg::lc3b_nzp cc_out;
lc3b_isa_pkg::lc3b_reg dr;
logic valid;
logic dep_stall;
logic decode_br_stall;

// stimulus for the next cycle, index 0 is execute, 1 is memory, 2 is writeback
logic s_reset;
logic [15:0] s_npc;
logic [15:0] s_ir;
logic [15:0] s_reg_data;
logic [2:0] s_cc_data;
logic [2:0] s_dest;
logic [2:0] s_drid [3];
logic [2:0] s_ld_reg;
logic [2:0] s_ld_cc;
logic s_valid;
logic s_ex_br;
logic s_mem_br;
logic s_mem_stall;

// reference model state and the expected ID/EX contents
logic [15:0] model_regs [8];
logic known [8];
logic [2:0] model_cc = '0;
logic [15:0] e_npc = '0;
logic [15:0] e_ir = '0;
logic [15:0] e_sr1 = '0;
logic [15:0] e_sr2 = '0;
lc3b_ctrl_pkg::lc3b_control_word e_cw = '0;
logic [2:0] e_cc = '0;
logic [2:0] e_dr = '0;
logic e_valid = 1'b0;
logic e_sr1_known = 1'b1;
logic e_sr2_known = 1'b1;

logic [15:0] lfsr = 16'd49722;
int n_tests = 0;
int n_checks = 0;
int n_errors = 0;
int start_checks = 0;
int start_errors = 0;

decode_stage dut_i (.*);

initial
begin
	clk = 1'b0;
	forever #5 clk = ~clk;
end

function automatic logic [15:0] lfsr_step(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic logic [15:0] rand_bits(input int n);
	logic [15:0] r;
	r = '0;
	for (int i = 0; i < n; i++)
	begin
		lfsr = lfsr_step(lfsr);
		r = {r[14:0], lfsr[0]};
	end
	return r;
endfunction

// expected control word, built field by field from the opcode
function automatic lc3b_ctrl_pkg::lc3b_control_word model_cw(input logic [15:0] w);
	lc3b_ctrl_pkg::lc3b_control_word c;
	logic [3:0] op;
	op = w[15:12];
	c = '0;
	if (op == 4'b1010 || op == 4'b1011)
		return c;
	c.opcode = lc3b_isa_pkg::lc3b_opcode'(op);
	c.ld_reg = op inside {lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and, lc3b_isa_pkg::op_not,
		lc3b_isa_pkg::op_shf, lc3b_isa_pkg::op_ldb, lc3b_isa_pkg::op_ldr, lc3b_isa_pkg::op_lea};
	c.ld_cc = c.ld_reg;
	c.sr1_needed = !(op inside {lc3b_isa_pkg::op_br, lc3b_isa_pkg::op_lea, lc3b_isa_pkg::op_trap})
		&& !(op == lc3b_isa_pkg::op_jsr && w[11]);
	c.regfilemux_sel = op inside {lc3b_isa_pkg::op_stb, lc3b_isa_pkg::op_str};
	c.sr2_needed = c.regfilemux_sel
		|| (op inside {lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and} && !w[5]);
	c.cc_needed = op == lc3b_isa_pkg::op_br;
	c.destmux_sel = op inside {lc3b_isa_pkg::op_jsr, lc3b_isa_pkg::op_trap};
	c.mem_read = op inside {lc3b_isa_pkg::op_ldb, lc3b_isa_pkg::op_ldr, lc3b_isa_pkg::op_trap};
	c.mem_write = c.regfilemux_sel;
	c.mem_byte = op inside {lc3b_isa_pkg::op_ldb, lc3b_isa_pkg::op_stb};
	case (op)
		lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_ldb, lc3b_isa_pkg::op_ldr,
		lc3b_isa_pkg::op_stb, lc3b_isa_pkg::op_str:
			c.aluop = lc3b_ctrl_pkg::alu_add;
		lc3b_isa_pkg::op_and:
			c.aluop = lc3b_ctrl_pkg::alu_and;
		lc3b_isa_pkg::op_not:
			c.aluop = lc3b_ctrl_pkg::alu_not;
		lc3b_isa_pkg::op_lea:
			c.aluop = lc3b_ctrl_pkg::alu_pass;
		lc3b_isa_pkg::op_shf:
			c.aluop = !w[4] ? lc3b_ctrl_pkg::alu_sll
				: (w[5] ? lc3b_ctrl_pkg::alu_sra : lc3b_ctrl_pkg::alu_srl);
		lc3b_isa_pkg::op_br:
			c.pc_ctrl = lc3b_ctrl_pkg::pc_branch;
		lc3b_isa_pkg::op_jmp, lc3b_isa_pkg::op_rti:
			c.pc_ctrl = lc3b_ctrl_pkg::pc_jump;
		lc3b_isa_pkg::op_jsr, lc3b_isa_pkg::op_trap:
			c.pc_ctrl = lc3b_ctrl_pkg::pc_sub;
		default:
			;
	endcase
	return c;
endfunction

function automatic logic reg_busy(input logic [2:0] idx);
	return (s_ld_reg[0] && s_drid[0] == idx) || (s_ld_reg[1] && s_drid[1] == idx)
		|| (s_ld_reg[2] && s_drid[2] == idx);
endfunction

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
	n_checks++;
	if (got !== want)
	begin
		n_errors++;
		$display("ERR %s got %h expected %h at %0t", name, got, want, $time);
	end
endtask

task automatic check_outputs();
	check_val("npc", 32'(npc), 32'(e_npc));
	check_val("ir", 32'(ir), 32'(e_ir));
	check_val("cw", 32'(cw), 32'(e_cw));
	check_val("cc_out", 32'(cc_out), 32'(e_cc));
	check_val("dr", 32'(dr), 32'(e_dr));
	check_val("valid", 32'(valid), 32'(e_valid));
	// register file has no reset, so unwritten entries are not compared
	if (e_sr1_known)
		check_val("sr1", 32'(sr1), 32'(e_sr1));
	if (e_sr2_known)
		check_val("sr2", 32'(sr2), 32'(e_sr2));
endtask

task automatic quiet();
	s_reset = 1'b0;
	s_npc = rand_bits(16);
	s_ir = '0;
	s_reg_data = '0;
	s_cc_data = '0;
	s_dest = '0;
	for (int k = 0; k < 3; k++)
		s_drid[k] = '0;
	s_ld_reg = '0;
	s_ld_cc = '0;
	s_valid = 1'b0;
	s_ex_br = 1'b0;
	s_mem_br = 1'b0;
	s_mem_stall = 1'b0;
endtask

// drives one cycle, checks the edge before it and predicts the next edge
task automatic apply_cycle();
	lc3b_ctrl_pkg::lc3b_control_word c;
	logic [2:0] i1;
	logic [2:0] i2;
	logic dep;
	logic brs;
	@(posedge clk);
	reset <= s_reset;
	npc_in <= s_npc;
	ir_in <= s_ir;
	reg_data <= s_reg_data;
	cc_data <= s_cc_data;
	dest_reg <= s_dest;
	ex_drid <= s_drid[0];
	mem_drid <= s_drid[1];
	wb_drid <= s_drid[2];
	ex_ld_reg <= s_ld_reg[0];
	mem_ld_reg <= s_ld_reg[1];
	wb_ld_reg <= s_ld_reg[2];
	ex_ld_cc <= s_ld_cc[0];
	mem_ld_cc <= s_ld_cc[1];
	wb_ld_cc <= s_ld_cc[2];
	valid_in <= s_valid;
	execute_br_stall <= s_ex_br;
	mem_stall <= s_mem_stall;
	mem_br_stall <= s_mem_br;
	@(negedge clk);
	check_outputs();
	c = model_cw(s_ir);
	i1 = s_ir[8:6];
	i2 = c.regfilemux_sel ? s_ir[11:9] : s_ir[2:0];
	dep = s_valid && ((c.sr1_needed && reg_busy(i1)) || (c.sr2_needed && reg_busy(i2))
		|| (c.cc_needed && (|s_ld_cc)));
	brs = s_valid && (c.pc_ctrl != lc3b_ctrl_pkg::pc_none);
	check_val("dep_stall", 32'(dep_stall), 32'(dep));
	check_val("decode_br_stall", 32'(decode_br_stall), 32'(brs));
	if (s_reset)
	begin
		e_npc = '0;
		e_ir = '0;
		e_sr1 = '0;
		e_sr2 = '0;
		e_cw = '0;
		e_cc = '0;
		e_dr = '0;
		e_valid = 1'b0;
		e_sr1_known = 1'b1;
		e_sr2_known = 1'b1;
	end
	else if (!s_mem_stall)
	begin
		e_npc = s_npc;
		e_ir = s_ir;
		e_sr1 = model_regs[i1];
		e_sr2 = model_regs[i2];
		e_sr1_known = known[i1];
		e_sr2_known = known[i2];
		e_cw = c;
		e_cc = model_cc;
		e_dr = c.destmux_sel ? 3'd7 : s_ir[11:9];
		e_valid = s_valid && !dep && !s_ex_br && !s_mem_br;
	end
	// write-back lands on the coming edge, after this cycle's reads
	if (s_ld_reg[2])
	begin
		model_regs[s_dest] = s_reg_data;
		known[s_dest] = 1'b1;
	end
	if (s_reset)
		model_cc = '0;
	else if (s_ld_cc[2])
		model_cc = s_cc_data;
endtask

task automatic end_test(input string name);
	quiet();
	apply_cycle();
	n_tests++;
	$display("test %-14s checks %0d errors %0d", name, n_checks - start_checks,
		n_errors - start_errors);
	start_checks = n_checks;
	start_errors = n_errors;
endtask

task automatic run_reset_test();
	quiet();
	s_reset = 1'b1;
	repeat (2)
		apply_cycle();
	check_val("valid", 32'(valid), 32'd0);
	check_val("cw", 32'(cw), 32'd0);
	for (int i = 0; i < 8; i++)
	begin
		quiet();
		s_dest = 3'(i);
		s_drid[2] = 3'(i);
		s_ld_reg = 3'b100;
		s_reg_data = rand_bits(16);
		apply_cycle();
	end
	// register-form ADDs read every entry back on both ports
	for (int i = 0; i < 8; i++)
	begin
		quiet();
		s_valid = 1'b1;
		s_ir = {4'b0001, 3'(rand_bits(3)), 3'(i), 3'b000, 3'(7 - i)};
		apply_cycle();
	end
	end_test("reset");
endtask

task automatic run_control_test();
	for (int i = 0; i < ctrl_len; i++)
	begin
		quiet();
		s_valid = 1'b1;
		s_ir = {4'(i), 12'(rand_bits(12))};
		apply_cycle();
	end
	end_test("control_store");
endtask

task automatic run_dep_test();
	for (int i = 0; i < dep_len; i++)
	begin
		quiet();
		s_valid = 1'b1;
		s_ir = rand_bits(16);
		for (int k = 0; k < 3; k++)
			s_drid[k] = 3'(rand_bits(3));
		s_ld_reg = 3'(rand_bits(3));
		s_dest = 3'(rand_bits(3));
		s_reg_data = rand_bits(16);
		apply_cycle();
	end
	end_test("reg_deps");
endtask

task automatic run_cc_test();
	for (int i = 0; i < cc_len; i++)
	begin
		quiet();
		s_valid = 1'b1;
		s_ir = rand_bits(16);
		if (rand_bits(1) == 16'd1)
			s_ir[15:12] = 4'b0000;
		for (int k = 0; k < 3; k++)
			s_ld_cc[k] = (rand_bits(2) == 16'd0);
		s_cc_data = 3'(rand_bits(3));
		apply_cycle();
	end
	end_test("cond_codes");
endtask

task automatic run_branch_test();
	for (int i = 0; i < br_len; i++)
	begin
		quiet();
		s_ir = rand_bits(16);
		s_valid = 1'(rand_bits(1));
		s_ex_br = (rand_bits(2) == 16'd0);
		s_mem_br = (rand_bits(2) == 16'd0);
		apply_cycle();
	end
	end_test("branch_stalls");
endtask

task automatic run_backpressure_test();
	for (int i = 0; i < bp_len; i++)
	begin
		quiet();
		s_ir = rand_bits(16);
		s_valid = 1'(rand_bits(1));
		for (int k = 0; k < 3; k++)
			s_drid[k] = 3'(rand_bits(3));
		s_ld_reg = 3'(rand_bits(3));
		s_ld_cc = 3'(rand_bits(3));
		s_dest = 3'(rand_bits(3));
		s_reg_data = rand_bits(16);
		s_cc_data = 3'(rand_bits(3));
		s_ex_br = (rand_bits(2) == 16'd0);
		s_mem_br = (rand_bits(2) == 16'd0);
		s_mem_stall = 1'(rand_bits(1));
		apply_cycle();
	end
	end_test("backpressure");
endtask

initial
begin
	reset <= 1'b1;
	npc_in <= '0;
	ir_in <= '0;
	reg_data <= '0;
	cc_data <= '0;
	dest_reg <= '0;
	ex_drid <= '0;
	mem_drid <= '0;
	wb_drid <= '0;
	ex_ld_reg <= 1'b0;
	mem_ld_reg <= 1'b0;
	wb_ld_reg <= 1'b0;
	ex_ld_cc <= 1'b0;
	mem_ld_cc <= 1'b0;
	wb_ld_cc <= 1'b0;
	valid_in <= 1'b0;
	execute_br_stall <= 1'b0;
	mem_stall <= 1'b0;
	mem_br_stall <= 1'b0;
	for (int k = 0; k < 8; k++)
	begin
		model_regs[k] = '0;
		known[k] = 1'b0;
	end
	run_reset_test();
	run_control_test();
	run_dep_test();
	run_cc_test();
	run_branch_test();
	run_backpressure_test();
	$display("tests %0d checks %0d errors %0d", n_tests, n_checks, n_errors);
	if (n_errors == 0)
		$display("*** PASSED ***");
	else
		$display("*** FAILED ***");
	$finish;
end

initial
begin
	#(2 * total_cycles * 10);
	$display("watchdog expired, the tests did not finish in %0d cycles", 2 * total_cycles);
	$display("*** FAILED ***");
	$finish;
end

endmodule : decode_stage_tb

/* src.f */
hdl/lc3b_isa_pkg.sv
hdl/lc3b_ctrl_pkg.sv
hdl/hazard_if.sv
hdl/control_rom.sv
hdl/reg_state.sv
hdl/hazard_unit.sv
hdl/id_ex_reg.sv
hdl/decode_stage.sv
tb/decode_stage_assertions.sv
tb/decode_stage_tb.sv

/* Makefile */
TOP = decode_stage_tb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: sim clean
